// File: include/cpuDatapath_macros.svh
// ##########################################################
// datapath width and status register bit positions
// status reset value
// ##########################################################
`ifndef CPU_DATAPATH_MACROS_SVH
`define CPU_DATAPATH_MACROS_SVH

// accumulator side is one byte wide
`define DATA_W 8

// status bits, NV1B DIZC order
`define STATUS_N   7
`define STATUS_V   6
`define STATUS_ONE 5
`define STATUS_D   3
`define STATUS_I   2
`define STATUS_Z   1
`define STATUS_C   0

// bit 5 high, I set, everything else clear
`define STATUS_RESET 8'h24

`endif

// File: source/cpuDatapathPkg.sv
// ##########################################################
// shared datapath types
// byte, register select, operation code, ALU flag bundle
// ##########################################################
`include "cpuDatapath_macros.svh"

package cpuDatapathPkg;

    // one data byte
    typedef logic [`DATA_W-1:0] byteT;

    // register select, REG_NONE suppresses write-back
    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y,
        REG_NONE
    } regSelT;

    // operation code, also selects the flag rule
    typedef enum logic [3:0] {
        OP_LOAD, OP_ADC, OP_SBC, OP_AND,
        OP_ORA,  OP_EOR, OP_LSR, OP_ROR,
        OP_CMP,  OP_SEC, OP_CLC, OP_SED,
        OP_CLD,  OP_SEI, OP_CLI, OP_CLV
    } aluOpT;

    // raw adder and shifter flags
    typedef struct packed {
        logic carry;
        logic overflow;
        logic halfCarry;
    } aluFlagsT;

endpackage

// File: source/aluCore.sv
// ##########################################################
// binary ALU
// add with carry, AND, OR, XOR, shift right
// carry, overflow and half carry out
// ##########################################################
`timescale 1ns/10ps
`include "cpuDatapath_macros.svh"

module aluCore (
    input  cpuDatapathPkg::aluOpT    op,
    input  cpuDatapathPkg::byteT     srcValue,
    input  cpuDatapathPkg::byteT     operand,
    input  logic                     carryIn,
    output cpuDatapathPkg::byteT     aluResult,
    output cpuDatapathPkg::aluFlagsT aluFlags
);

    cpuDatapathPkg::byteT addB;
    logic                 addCin;
    logic [`DATA_W:0]     sum;
    logic [4:0]           lowSum;
    logic                 sumOverflow;

    // subtract and compare add the inverted operand
    assign addB = (op == cpuDatapathPkg::OP_SBC || op == cpuDatapathPkg::OP_CMP) ?
                  ~operand : operand;
    // compare never borrows in
    assign addCin = (op == cpuDatapathPkg::OP_CMP) ? 1'b1 : carryIn;

    assign sum    = {1'b0, srcValue} + {1'b0, addB} + addCin;
    // half carry out of bit 3, carry in counted
    assign lowSum = {1'b0, srcValue[3:0]} + {1'b0, addB[3:0]} + addCin;
    // same sign in, other sign out
    assign sumOverflow = (srcValue[`DATA_W-1] == addB[`DATA_W-1]) &&
                         (sum[`DATA_W-1] != srcValue[`DATA_W-1]);

    always_comb begin
        // flag ops see the source and keep C
        aluResult          = srcValue;
        aluFlags.carry     = carryIn;
        aluFlags.overflow  = 1'b0;
        aluFlags.halfCarry = 1'b0;
        case (op)
            cpuDatapathPkg::OP_LOAD: aluResult = operand;
            cpuDatapathPkg::OP_ADC, cpuDatapathPkg::OP_SBC, cpuDatapathPkg::OP_CMP: begin
                aluResult          = sum[`DATA_W-1:0];
                aluFlags.carry     = sum[`DATA_W];
                aluFlags.overflow  = sumOverflow;
                aluFlags.halfCarry = lowSum[4];
            end
            cpuDatapathPkg::OP_AND: aluResult = srcValue & operand;
            cpuDatapathPkg::OP_ORA: aluResult = srcValue | operand;
            cpuDatapathPkg::OP_EOR: aluResult = srcValue ^ operand;
            cpuDatapathPkg::OP_LSR: begin
                // zero shifted into the top
                aluResult      = {1'b0, srcValue[`DATA_W-1:1]};
                aluFlags.carry = srcValue[0];
            end
            cpuDatapathPkg::OP_ROR: begin
                // old C rotates into the top
                aluResult      = {carryIn, srcValue[`DATA_W-1:1]};
                aluFlags.carry = srcValue[0];
            end
            default: ;
        endcase
    end

endmodule

// File: source/decimalAdjust.sv
// ##########################################################
// BCD correction of the adder result
// decimal carry for ADC, pass-through otherwise
// ##########################################################
`timescale 1ns/10ps

module decimalAdjust (
    input  cpuDatapathPkg::aluOpT    op,
    input  logic                     decimalMode,
    input  cpuDatapathPkg::byteT     aluResult,
    input  cpuDatapathPkg::aluFlagsT aluFlags,
    output cpuDatapathPkg::byteT     adjResult,
    output logic                     decimalCarry
);

    always_comb begin
        // binary mode and non-adder ops pass straight through
        adjResult    = aluResult;
        decimalCarry = aluFlags.carry;
        if (decimalMode && op == cpuDatapathPkg::OP_ADC) begin
            // low digit past 9 or carried out
            if (aluResult[3:0] > 4'd9 || aluFlags.halfCarry) begin
                adjResult = adjResult + 8'h06;
            end
            // high digit, tested on the raw sum
            if (aluFlags.carry || aluResult > 8'h99) begin
                adjResult    = adjResult + 8'h60;
                decimalCarry = 1'b1;
            end
        end else if (decimalMode && op == cpuDatapathPkg::OP_SBC) begin
            // no half carry means the low digit borrowed
            if (!aluFlags.halfCarry) begin
                adjResult = adjResult - 8'h06;
            end
            // no carry means the high digit borrowed
            if (!aluFlags.carry) begin
                adjResult = adjResult - 8'h60;
            end
            // carry stays as the binary subtract left it
        end
    end

endmodule

// File: source/flagUnit.sv
// ##########################################################
// processor status register
// per-operation flag update on accept
// C and D fed back to the ALU
// ##########################################################
`timescale 1ns/10ps
`include "cpuDatapath_macros.svh"

module flagUnit (
    input  logic                     phi2,
    input  logic                     rstN,
    input  logic                     accept,
    input  cpuDatapathPkg::aluOpT    cmdOp,
    input  cpuDatapathPkg::byteT     adjResult,
    input  cpuDatapathPkg::aluFlagsT aluFlags,
    input  logic                     decimalCarry,
    output logic                     carryIn,
    output logic                     decimalMode,
    output cpuDatapathPkg::byteT     status
);

    cpuDatapathPkg::byteT statusQ;
    logic                 resultZero;
    logic                 resultNeg;

    assign resultZero = (adjResult == '0);
    assign resultNeg  = adjResult[`DATA_W-1];

    // bits 5 and 4 are only ever written by reset
    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            statusQ <= `STATUS_RESET;
        end else if (accept) begin
            case (cmdOp)
                cpuDatapathPkg::OP_LOAD, cpuDatapathPkg::OP_AND,
                cpuDatapathPkg::OP_ORA,  cpuDatapathPkg::OP_EOR: begin
                    // NZ only
                    statusQ[`STATUS_N] <= resultNeg;
                    statusQ[`STATUS_Z] <= resultZero;
                end
                cpuDatapathPkg::OP_ADC, cpuDatapathPkg::OP_SBC: begin
                    // NZVC, C after decimal fix-up
                    statusQ[`STATUS_N] <= resultNeg;
                    statusQ[`STATUS_Z] <= resultZero;
                    statusQ[`STATUS_V] <= aluFlags.overflow;
                    statusQ[`STATUS_C] <= decimalCarry;
                end
                cpuDatapathPkg::OP_LSR, cpuDatapathPkg::OP_ROR,
                cpuDatapathPkg::OP_CMP: begin
                    // NZC, V untouched
                    statusQ[`STATUS_N] <= resultNeg;
                    statusQ[`STATUS_Z] <= resultZero;
                    statusQ[`STATUS_C] <= aluFlags.carry;
                end
                // single-flag commands
                cpuDatapathPkg::OP_SEC: statusQ[`STATUS_C] <= 1'b1;
                cpuDatapathPkg::OP_CLC: statusQ[`STATUS_C] <= 1'b0;
                cpuDatapathPkg::OP_SED: statusQ[`STATUS_D] <= 1'b1;
                cpuDatapathPkg::OP_CLD: statusQ[`STATUS_D] <= 1'b0;
                cpuDatapathPkg::OP_SEI: statusQ[`STATUS_I] <= 1'b1;
                cpuDatapathPkg::OP_CLI: statusQ[`STATUS_I] <= 1'b0;
                cpuDatapathPkg::OP_CLV: statusQ[`STATUS_V] <= 1'b0;
                default: ;
            endcase
        end
    end

    // feedback into the adder and the BCD stage
    assign carryIn     = statusQ[`STATUS_C];
    assign decimalMode = statusQ[`STATUS_D];
    assign status      = statusQ;

endmodule

// File: source/registerBank.sv
// ##########################################################
// A, X and Y registers
// command accept, source select, result write-back
// ##########################################################
`timescale 1ns/10ps

module registerBank (
    input  logic                   phi2,
    input  logic                   rstN,
    input  logic                   cmdValid,
    input  logic                   hold,
    input  cpuDatapathPkg::regSelT cmdSrc,
    input  cpuDatapathPkg::regSelT cmdDst,
    input  cpuDatapathPkg::aluOpT  cmdOp,
    input  cpuDatapathPkg::byteT   adjResult,
    output logic                   accept,
    output cpuDatapathPkg::byteT   srcValue,
    output cpuDatapathPkg::byteT   regA,
    output cpuDatapathPkg::byteT   regX,
    output cpuDatapathPkg::byteT   regY
);

    logic writeEn;

    // hold freezes everything, a command under hold is dropped
    assign accept = cmdValid && !hold;

    // compare and the set/clear ops only touch flags
    assign writeEn = accept && cmdDst != cpuDatapathPkg::REG_NONE &&
                     cmdOp != cpuDatapathPkg::OP_CMP && cmdOp < cpuDatapathPkg::OP_SEC;

    // first ALU operand, zero when no register named
    always_comb begin
        case (cmdSrc)
            cpuDatapathPkg::REG_A: srcValue = regA;
            cpuDatapathPkg::REG_X: srcValue = regX;
            cpuDatapathPkg::REG_Y: srcValue = regY;
            default:               srcValue = '0;
        endcase
    end

    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            regA <= '0;
            regX <= '0;
            regY <= '0;
        end else if (writeEn) begin
            if (cmdDst == cpuDatapathPkg::REG_A) regA <= adjResult;
            if (cmdDst == cpuDatapathPkg::REG_X) regX <= adjResult;
            if (cmdDst == cpuDatapathPkg::REG_Y) regY <= adjResult;
        end
    end

endmodule

// File: source/cpuDatapathTop.sv
// ##########################################################
// accumulator-side datapath top level
// register bank, ALU, decimal adjust, status register
// ##########################################################
`timescale 1ns/10ps

module cpuDatapathTop (
    input  logic                   phi2,
    input  logic                   rstN,
    input  logic                   cmdValid,
    input  logic                   hold,
    input  cpuDatapathPkg::aluOpT  cmdOp,
    input  cpuDatapathPkg::regSelT cmdSrc,
    input  cpuDatapathPkg::byteT   cmdOperand,
    input  cpuDatapathPkg::regSelT cmdDst,
    output cpuDatapathPkg::byteT   regA,
    output cpuDatapathPkg::byteT   regX,
    output cpuDatapathPkg::byteT   regY,
    output cpuDatapathPkg::byteT   status
);

    logic                     accept;
    logic                     carryIn;
    logic                     decimalMode;
    logic                     decimalCarry;
    cpuDatapathPkg::byteT     srcValue;
    cpuDatapathPkg::byteT     aluResult;
    cpuDatapathPkg::byteT     adjResult;
    cpuDatapathPkg::aluFlagsT aluFlags;

    // registers and command accept
    registerBank uRegs (.phi2, .rstN, .cmdValid, .hold, .cmdSrc, .cmdDst, .cmdOp,
                        .adjResult, .accept, .srcValue, .regA, .regX, .regY);

    // combinational path, source and operand to adjusted result
    aluCore uAlu (.op(cmdOp), .srcValue, .operand(cmdOperand), .carryIn,
                  .aluResult, .aluFlags);

    decimalAdjust uDec (.op(cmdOp), .decimalMode, .aluResult, .aluFlags,
                        .adjResult, .decimalCarry);

    // status register, same accepting edge as the registers
    flagUnit uFlags (.phi2, .rstN, .accept, .cmdOp, .adjResult, .aluFlags,
                     .decimalCarry, .carryIn, .decimalMode, .status);

endmodule

// File: tb/cpuDatapathTop_tb.sv
// ##########################################################
// testbench for the accumulator datapath top level
// clock and reset, pattern file replay, LFSR hold insertion
// typed compare tasks and error summary
// ##########################################################
`timescale 1ns/10ps

module cpuDatapathTop_tb;

    localparam int acceptTimeout = 20;

    logic                   phi2;
    logic                   rstN;
    logic                   cmdValid;
    logic                   hold;
    cpuDatapathPkg::aluOpT  cmdOp;
    cpuDatapathPkg::regSelT cmdSrc;
    cpuDatapathPkg::byteT   cmdOperand;
    cpuDatapathPkg::regSelT cmdDst;
    cpuDatapathPkg::byteT   regA;
    cpuDatapathPkg::byteT   regX;
    cpuDatapathPkg::byteT   regY;
    cpuDatapathPkg::byteT   status;

    // current pattern line
    integer               patFile;
    reg [8*128-1:0]       lineBuf;
    reg [8*20-1:0]        curName;
    logic [3:0]           curOp;
    logic [1:0]           curSrc;
    logic [1:0]           curDst;
    cpuDatapathPkg::byteT curOperand;
    cpuDatapathPkg::byteT curA, curX, curY, curStatus;
    // accepted command waiting for its check
    reg [8*20-1:0]        chkName;
    cpuDatapathPkg::byteT chkA, chkX, chkY, chkStatus;
    // last known state as reference for held edges
    cpuDatapathPkg::byteT lastA, lastX, lastY, lastStatus;

    logic [31:0] lfsr;
    integer      errorCount;
    integer      timeoutCount;
    integer      checkCount;
    integer      holdCount;
    integer      patternCount;

    cpuDatapathTop dut_i (.phi2, .rstN, .cmdValid, .hold, .cmdOp, .cmdSrc, .cmdOperand,
                          .cmdDst, .regA, .regX, .regY, .status);

    initial begin
        phi2 = 1'b0;
        forever #5 phi2 = ~phi2;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBit(output logic b);
        lfsr = lfsrStep(lfsr);
        b = lfsr[0];
    endtask

    task automatic checkByte(input reg [8*20-1:0] testName, input string what,
                             input cpuDatapathPkg::byteT expected,
                             input cpuDatapathPkg::byteT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %0s %s expected %02h actual %02h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkStatus(input reg [8*20-1:0] testName,
                               input cpuDatapathPkg::byteT expected,
                               input cpuDatapathPkg::byteT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %0s status expected %02h actual %02h (NV1BDIZC)",
                     testName, expected, actual);
        end
    endtask

    // skips comments and blanks up to a line with all nine fields
    task automatic readPattern(output logic got);
        integer fields;
        got = 1'b0;
        while (!got && !$feof(patFile)) begin
            lineBuf = '0;
            if ($fgets(lineBuf, patFile) != 0) begin
                fields = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h", curName, curOp,
                                 curSrc, curDst, curOperand, curA, curX, curY, curStatus);
                if (fields == 9) got = 1'b1;
            end
        end
    endtask

    // hold raised for one edge when both drawn bits are one
    task automatic driveCommand();
        logic b0;
        logic b1;
        drawBit(b0);
        drawBit(b1);
        cmdValid   <= 1'b1;
        hold       <= b0 & b1;
        cmdOp      <= cpuDatapathPkg::aluOpT'(curOp);
        cmdSrc     <= cpuDatapathPkg::regSelT'(curSrc);
        cmdDst     <= cpuDatapathPkg::regSelT'(curDst);
        cmdOperand <= curOperand;
    endtask

    // returns just after the accepting edge
    task automatic waitAccept(output logic ok);
        integer cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < acceptTimeout) begin
            @(posedge phi2);
            cycles++;
            if (hold) begin
                hold <= 1'b0;
                holdCount++;
                // held edge leaves every register alone
                @(negedge phi2);
                checkByte(curName, "A under hold", lastA, regA);
                checkByte(curName, "X under hold", lastX, regX);
                checkByte(curName, "Y under hold", lastY, regY);
                checkStatus(curName, lastStatus, status);
            end else if (cmdValid) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            timeoutCount++;
            $display("timeout: command %0s was not accepted within %0d cycles",
                     curName, acceptTimeout);
        end
    endtask

    initial begin
        logic got;
        logic ok;
        rstN = 1'b0;
        cmdValid = 1'b0;
        hold = 1'b0;
        cmdOp = cpuDatapathPkg::OP_LOAD;
        cmdSrc = cpuDatapathPkg::REG_A;
        cmdOperand = '0;
        cmdDst = cpuDatapathPkg::REG_NONE;
        lfsr = 32'h910f;
        errorCount = 0;
        timeoutCount = 0;
        checkCount = 0;
        holdCount = 0;
        patternCount = 0;
        lastA = 8'h00;
        lastX = 8'h00;
        lastY = 8'h00;
        lastStatus = 8'h24;

        repeat (4) @(posedge phi2);
        rstN <= 1'b1;
        @(negedge phi2);
        checkByte("reset", "A", 8'h00, regA);
        checkByte("reset", "X", 8'h00, regX);
        checkByte("reset", "Y", 8'h00, regY);
        checkStatus("reset", 8'h24, status);

        patFile = $fopen("tb/aluPatterns.txt", "r");
        got = 1'b0;
        if (patFile == 0) begin
            errorCount++;
            $display("error: cannot open pattern file tb/aluPatterns.txt");
        end else begin
            @(posedge phi2);
            readPattern(got);
            if (got) driveCommand();
        end

        // next command goes out on the accepting edge for back-to-back issue
        while (got) begin
            waitAccept(ok);
            if (ok) begin
                chkName = curName;
                chkA = curA;
                chkX = curX;
                chkY = curY;
                chkStatus = curStatus;
                readPattern(got);
                if (got) driveCommand();
                else cmdValid <= 1'b0;
                @(negedge phi2);
                checkByte(chkName, "A", chkA, regA);
                checkByte(chkName, "X", chkX, regX);
                checkByte(chkName, "Y", chkY, regY);
                checkStatus(chkName, chkStatus, status);
                lastA = chkA;
                lastX = chkX;
                lastY = chkY;
                lastStatus = chkStatus;
                patternCount++;
            end else begin
                got = 1'b0;
            end
        end
        if (patFile != 0) $fclose(patFile);
        if (patternCount == 0) begin
            errorCount++;
            $display("error: no command was replayed from the pattern file");
        end

        $display("summary: %0d patterns, %0d checks, %0d errors, %0d timeouts, %0d held edges",
                 patternCount, checkCount, errorCount, timeoutCount, holdCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb/aluPatterns.txt
# test op src dst operand expA expX expY expStatus, all hex after the test name
# op: 0 LOAD 1 ADC 2 SBC 3 AND 4 ORA 5 EOR 6 LSR 7 ROR 8 CMP 9 SEC a CLC b SED c CLD d SEI e CLI f CLV; reg: 0 A 1 X 2 Y 3 none
load_a         0 0 0 80 80 00 00 a4
load_x         0 0 1 00 80 00 00 26
load_y         0 0 2 3c 80 00 3c 24
and_a          3 0 0 f0 80 00 3c a4
ora_a          4 0 0 0f 8f 00 3c a4
eor_a          5 0 0 8f 00 00 3c 26
and_y_x        3 2 1 0f 00 0c 3c 24
eor_x          5 1 1 ff 00 f3 3c a4
load_a50       0 0 0 50 50 f3 3c 24
adc_ovf        1 0 0 50 a0 f3 3c e4
sec_1          9 0 3 00 a0 f3 3c e5
adc_carry      1 0 0 70 11 f3 3c 25
sbc_borrow     2 0 0 20 f1 f3 3c a4
sbc_noborrow   2 0 0 01 ef f3 3c a5
sbc_ovf        2 0 0 70 7f f3 3c 65
cmp_eq         8 0 0 7f 7f f3 3c 67
cmp_lt         8 0 0 90 7f f3 3c e4
clv_1          f 0 3 00 7f f3 3c a4
sed_1          b 0 3 00 7f f3 3c ac
clc_1          a 0 3 00 7f f3 3c ac
load_a58       0 0 0 58 58 f3 3c 2c
adc_bcd        1 0 0 46 04 f3 3c 6d
sbc_bcd_borrow 2 0 0 05 99 f3 3c ac
sbc_bcd        2 0 0 19 79 f3 3c 6d
cld_1          c 0 3 00 79 f3 3c 65
adc_bin        1 0 0 19 93 f3 3c e4
lsr_a          6 0 0 00 49 f3 3c 65
ror_a          7 0 0 00 a4 f3 3c e5
lsr_y_x        6 2 1 00 a4 1e 3c 64
ror_x          7 1 1 00 a4 0f 3c 64
eor_none       5 0 3 a4 a4 0f 3c 66
sec_2          9 0 3 00 a4 0f 3c 67
cli_1          e 0 3 00 a4 0f 3c 63
sei_1          d 0 3 00 a4 0f 3c 67
clc_2          a 0 3 00 a4 0f 3c 66
clv_2          f 0 3 00 a4 0f 3c 26

// File: cpuDatapath.f
+incdir+include
source/cpuDatapathPkg.sv
source/aluCore.sv
source/decimalAdjust.sv
source/flagUnit.sv
source/registerBank.sv
source/cpuDatapathTop.sv
tb/cpuDatapathTop_tb.sv
